// ==== Bender.yml ====
package:
  name: bch_syndrome

sources:
  - rtl/bch_gf_pkg.sv
  - rtl/bch_code_pkg.sv
  - rtl/bch_lfsr_counter.sv
  - rtl/bch_dsyn.sv
  - rtl/bch_syndrome.sv
  - rtl/bch_syndrome_expand.sv
  - rtl/bch_syndrome_top.sv

  - target: test
    files:
      - tests/bch_syndrome_checker.sv
      - tests/bch_syndrome_tb.sv

// ==== bch_syndrome_top.f ====
rtl/bch_gf_pkg.sv
rtl/bch_code_pkg.sv
rtl/bch_lfsr_counter.sv
rtl/bch_dsyn.sv
rtl/bch_syndrome.sv
rtl/bch_syndrome_expand.sv
rtl/bch_syndrome_top.sv
tests/bch_syndrome_checker.sv
tests/bch_syndrome_tb.sv

// ==== rtl/bch_code_pkg.sv ====
package bch_code_pkg;

	localparam int code_n = 15;                          // Code length in bits

	localparam int code_t = 2;                           // Correctable errors

	localparam int syn_count = code_t;                   // Odd syndromes S1 .. S(2t-1)

	// Counter state 13 steps after restart, i.e. code_n - 2
	localparam bch_gf_pkg::gf_elem_t cnt_done = 4'hc;

	typedef enum logic {
		idle,                                            // Waiting for start
		busy                                             // Accepting a word
	} syn_state_t;

endpackage

// ==== rtl/bch_dsyn.sv ====
`timescale 1ns/1ps

module bch_dsyn #(
	parameter int syn_index = 1
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 clear,
	input  logic                 enable,
	input  logic                 data_in,
	output bch_gf_pkg::gf_elem_t syn
);

	bch_gf_pkg::gf_elem_t product;

	// Shift-and-add multiply, folds to XOR logic for a constant operand
	function automatic bch_gf_pkg::gf_elem_t gf_mul(
		input bch_gf_pkg::gf_elem_t a,
		input bch_gf_pkg::gf_elem_t b
	);
		bch_gf_pkg::gf_elem_t acc;
		bch_gf_pkg::gf_elem_t sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < bch_gf_pkg::gf_m; i++) begin
			if (b[i]) begin
				acc = acc ^ sh;
			end
			if (sh[bch_gf_pkg::gf_m-1]) begin
				sh = {sh[bch_gf_pkg::gf_m-2:0], 1'b0} ^ bch_gf_pkg::gf_poly[bch_gf_pkg::gf_m-1:0];
			end else begin
				sh = {sh[bch_gf_pkg::gf_m-2:0], 1'b0};
			end
		end
		return acc;
	endfunction

	assign product = gf_mul(syn, bch_gf_pkg::alpha_pow[syn_index % bch_code_pkg::code_n]);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			syn <= '0;
		end else if (enable) begin
			if (clear) begin
				syn <= bch_gf_pkg::gf_elem_t'(data_in);      // First bit of a new word
			end else begin
				syn <= product ^ bch_gf_pkg::gf_elem_t'(data_in); // Horner step
			end
		end
	end

endmodule

// ==== rtl/bch_gf_pkg.sv ====
package bch_gf_pkg;

	localparam int gf_m = 4;                             // Bits per field element

	localparam logic [gf_m:0] gf_poly = 5'b1_0011;       // x^4 + x + 1

	typedef logic [gf_m-1:0] gf_elem_t;

	// Powers of the primitive element, index is the exponent
	localparam gf_elem_t alpha_pow [0:14] = '{
		4'h1,                                            // alpha^0
		4'h2,
		4'h4,
		4'h8,
		4'h3,                                            // alpha^4 = alpha + 1
		4'h6,
		4'hc,
		4'hb,
		4'h5,
		4'ha,
		4'h7,
		4'he,
		4'hf,
		4'hd,
		4'h9                                             // alpha^14
	};

endpackage

// ==== rtl/bch_lfsr_counter.sv ====
`timescale 1ns/1ps

module bch_lfsr_counter (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 restart,
	input  logic                 step,
	output bch_gf_pkg::gf_elem_t count
);

	logic feedback;

	// Fibonacci taps are the reversed low bits of the field polynomial
	always_comb begin
		feedback = 1'b0;
		for (int i = 0; i < bch_gf_pkg::gf_m; i++) begin
			feedback = feedback ^ (count[i] & bch_gf_pkg::gf_poly[bch_gf_pkg::gf_m-1-i]);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= bch_gf_pkg::gf_elem_t'(1);              // Never the lock-up state
		end else if (restart) begin
			count <= bch_gf_pkg::gf_elem_t'(1);
		end else if (step) begin
			count <= {count[bch_gf_pkg::gf_m-2:0], feedback};
		end
	end

endmodule

// ==== rtl/bch_syndrome.sv ====
`timescale 1ns/1ps

module bch_syndrome (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  logic                 ce,
	input  logic                 data_in,
	output logic                 ready,
	output logic                 syn_done,
	output bch_gf_pkg::gf_elem_t s1_raw,
	output bch_gf_pkg::gf_elem_t s3_raw
);

	bch_code_pkg::syn_state_t state;
	bch_gf_pkg::gf_elem_t     count;
	bch_gf_pkg::gf_elem_t     syn_raw [bch_code_pkg::syn_count];
	logic                     restart;
	logic                     step;
	logic                     accumulate;
	logic                     last_bit;

	assign restart    = start && ce;                         // Accepts r14
	assign step       = (state == bch_code_pkg::busy) && ce;
	assign accumulate = ((state == bch_code_pkg::busy) || start) && ce;
	assign last_bit   = ce && (count == bch_code_pkg::cnt_done); // Accepts r0

	assign ready = (state == bch_code_pkg::idle);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= bch_code_pkg::idle;
			syn_done <= 1'b0;
		end else begin
			syn_done <= 1'b0;
			case (state)
				bch_code_pkg::idle: begin
					if (restart) begin
						state <= bch_code_pkg::busy;
					end
				end
				bch_code_pkg::busy: begin
					if (last_bit) begin
						state    <= bch_code_pkg::idle;
						syn_done <= 1'b1;
					end
				end
				default: begin
					state <= bch_code_pkg::idle;
				end
			endcase
		end
	end

	bch_lfsr_counter bch_lfsr_counter_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.restart (restart),
		.step    (step),
		.count   (count)
	);

	// One accumulator per odd syndrome, S1 then S3
	for (genvar i = 0; i < bch_code_pkg::syn_count; i++) begin : g_syn
		bch_dsyn #(
			.syn_index (2 * i + 1)
		) bch_dsyn_inst (
			.clk     (clk),
			.rst_n   (rst_n),
			.clear   (start),
			.enable  (accumulate),
			.data_in (data_in),
			.syn     (syn_raw[i])
		);
	end

	assign s1_raw = syn_raw[0];
	assign s3_raw = syn_raw[1];

endmodule

// ==== rtl/bch_syndrome_expand.sv ====
`timescale 1ns/1ps

module bch_syndrome_expand (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 syn_done,
	input  bch_gf_pkg::gf_elem_t s1_raw,
	input  bch_gf_pkg::gf_elem_t s3_raw,
	output logic                 syn_valid,
	output bch_gf_pkg::gf_elem_t syn1,
	output bch_gf_pkg::gf_elem_t syn2,
	output bch_gf_pkg::gf_elem_t syn3,
	output logic                 errors_present
);

	bch_gf_pkg::gf_elem_t s2_sq;

	// Squaring is linear: a0 + a1 x^2 + a2 (x + 1) + a3 (x^3 + x^2)
	assign s2_sq[0] = s1_raw[0] ^ s1_raw[2];
	assign s2_sq[1] = s1_raw[2];
	assign s2_sq[2] = s1_raw[1] ^ s1_raw[3];
	assign s2_sq[3] = s1_raw[3];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			syn_valid <= 1'b0;
		end else begin
			syn_valid <= syn_done;                           // One clock after done
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			syn1           <= '0;
			syn2           <= '0;
			syn3           <= '0;
			errors_present <= 1'b0;
		end else if (syn_done) begin
			syn1           <= s1_raw;
			syn2           <= s2_sq;
			syn3           <= s3_raw;
			errors_present <= |{s1_raw, s3_raw};            // S2 is zero iff S1 is
		end
	end

endmodule

// ==== rtl/bch_syndrome_top.sv ====
`timescale 1ns/1ps

module bch_syndrome_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  logic                 ce,
	input  logic                 data_in,
	output logic                 ready,
	output logic                 syn_valid,
	output bch_gf_pkg::gf_elem_t syn1,
	output bch_gf_pkg::gf_elem_t syn2,
	output bch_gf_pkg::gf_elem_t syn3,
	output logic                 errors_present
);

	logic                 syn_done;
	bch_gf_pkg::gf_elem_t s1_raw;
	bch_gf_pkg::gf_elem_t s3_raw;

	bch_syndrome bch_syndrome_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.ce       (ce),
		.data_in  (data_in),
		.ready    (ready),
		.syn_done (syn_done),
		.s1_raw   (s1_raw),
		.s3_raw   (s3_raw)
	);

	// Registers the previous result while the next word accumulates
	bch_syndrome_expand bch_syndrome_expand_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.syn_done       (syn_done),
		.s1_raw         (s1_raw),
		.s3_raw         (s3_raw),
		.syn_valid      (syn_valid),
		.syn1           (syn1),
		.syn2           (syn2),
		.syn3           (syn3),
		.errors_present (errors_present)
	);

endmodule

// ==== tests/bch_syndrome_checker.sv ====
`timescale 1ns/1ps

module bch_syndrome_checker (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 start,
	input logic                 ce,
	input logic                 ready,
	input logic                 syn_valid,
	input bch_gf_pkg::gf_elem_t syn1,
	input bch_gf_pkg::gf_elem_t syn2,
	input bch_gf_pkg::gf_elem_t syn3,
	input logic                 errors_present
);

	// syn_valid is a single-clock pulse
	single_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		syn_valid |=> !syn_valid)
		else $error("syn_valid high on two consecutive cycles");

	ready_falls_on_start: assert property (@(posedge clk) disable iff (!rst_n)
		(start && ce && ready) |=> !ready)
		else $error("ready still high after an accepted start");

	// ready only returns one clock ahead of the result
	ready_returns_with_result: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ready) |=> syn_valid)
		else $error("ready rose without a following syn_valid");

	outputs_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!syn_valid |-> $stable({syn1, syn2, syn3, errors_present}))
		else $error("syndrome outputs changed between syn_valid pulses");

endmodule

bind bch_syndrome_top bch_syndrome_checker bch_syndrome_checker_inst (
	.clk            (clk),
	.rst_n          (rst_n),
	.start          (start),
	.ce             (ce),
	.ready          (ready),
	.syn_valid      (syn_valid),
	.syn1           (syn1),
	.syn2           (syn2),
	.syn3           (syn3),
	.errors_present (errors_present)
);

// ==== tests/bch_syndrome_tb.sv ====
`timescale 1ns/1ps

module bch_syndrome_tb;

	localparam int         seed       = 13;
	localparam logic [8:0] gen_poly   = 9'b1_1101_0001;  // x^8 + x^7 + x^6 + x^4 + 1
	localparam logic [4:0] field_poly = 5'b1_0011;       // x^4 + x + 1
	localparam int         wait_limit = 200;             // Clocks before any wait gives up

	logic       clk;
	logic       rst_n;
	logic       start;
	logic       ce;
	logic       data_in;
	logic       ready;
	logic       syn_valid;
	logic [3:0] syn1;
	logic [3:0] syn2;
	logic [3:0] syn3;
	logic       errors_present;

	logic [12:0] exp_q [$];                              // {errors_present, S1, S2, S3}
	int          exp_cycle_q [$];                        // Cycle where syn_valid is due
	int          cycle;
	int          sent;
	int          checked;
	int          error_count;

	bch_syndrome_top bch_syndrome_top_inst (
		.clk            (clk),
		.rst_n          (rst_n),
		.start          (start),
		.ce             (ce),
		.data_in        (data_in),
		.ready          (ready),
		.syn_valid      (syn_valid),
		.syn1           (syn1),
		.syn2           (syn2),
		.syn3           (syn3),
		.errors_present (errors_present)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// Carry-less product, then reduction from the top bit down
	function automatic logic [3:0] gf_mult(input logic [3:0] a, input logic [3:0] b);
		logic [6:0] prod;
		prod = '0;
		for (int i = 0; i < 4; i++) begin
			if (b[i]) begin
				prod = prod ^ (7'(a) << i);
			end
		end
		for (int i = 6; i >= 4; i--) begin
			if (prod[i]) begin
				prod = prod ^ (7'(field_poly) << (i - 4));
			end
		end
		return prod[3:0];
	endfunction

	function automatic logic [3:0] poly_eval(input logic [14:0] word, input logic [3:0] x);
		logic [3:0] acc;
		logic [3:0] pw;
		acc = '0;
		pw = 4'h1;
		for (int i = 0; i < 15; i++) begin
			if (word[i]) begin
				acc = acc ^ pw;
			end
			pw = gf_mult(pw, x);
		end
		return acc;
	endfunction

	function automatic logic [12:0] ref_syndromes(input logic [14:0] word);
		logic [3:0] s1;
		logic [3:0] s2;
		logic [3:0] s3;
		s1 = poly_eval(word, 4'h2);                          // r(alpha)
		s2 = poly_eval(word, gf_mult(4'h2, 4'h2));
		s3 = poly_eval(word, gf_mult(4'h2, gf_mult(4'h2, 4'h2)));
		return {(s1 != 4'h0) || (s3 != 4'h0), s1, s2, s3};
	endfunction

	function automatic logic [14:0] encode(input logic [6:0] msg);
		logic [14:0] cw;
		cw = '0;
		for (int i = 0; i < 7; i++) begin
			if (msg[i]) begin
				cw = cw ^ (15'(gen_poly) << i);
			end
		end
		return cw;
	endfunction

	// Flips up to two distinct random positions
	function automatic logic [14:0] add_errors(input logic [14:0] word, input int count);
		logic [14:0] result;
		int          p1;
		int          p2;
		result = word;
		p1 = $urandom_range(0, 14);
		p2 = (p1 + $urandom_range(1, 14)) % 15;
		if (count >= 1) begin
			result[p1] = ~result[p1];
		end
		if (count >= 2) begin
			result[p2] = ~result[p2];
		end
		return result;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic compare_value(input logic [31:0] got, input logic [31:0] expected,
		input string what);
		if (got !== expected) begin
			error_count++;
			abort_run($sformatf("mismatch at %0t: %s is %0h, expected %0h",
				$time, what, got, expected));
		end
	endtask

	task automatic drive_cycle(input logic st, input logic en, input logic bit_in,
		input logic ready_exp, output int at_cycle);
		@(posedge clk);
		at_cycle = cycle;
		start   <= st;
		ce      <= en;
		data_in <= bit_in;
		@(negedge clk);
		compare_value(32'(ready), 32'(ready_exp), "ready");
	endtask

	task automatic wait_ready;
		int waited;
		waited = 0;
		@(posedge clk);
		start <= 1'b0;
		ce    <= 1'b0;
		@(negedge clk);
		while (!ready) begin
			waited++;
			if (waited > wait_limit) begin
				abort_run("timeout while waiting for ready to return");
			end
			@(negedge clk);
		end
	endtask

	// MSB first; a back-to-back word starts on the edge that accepts the previous r0
	task automatic send_word(input logic [14:0] word, input bit gaps, input bit back_to_back);
		int at_cycle;
		int gap;
		if (!back_to_back) begin
			wait_ready();
		end
		exp_q.push_back(ref_syndromes(word));
		for (int k = 14; k >= 0; k--) begin
			gap = (gaps && !(back_to_back && k == 14)) ? $urandom_range(0, 2) : 0;
			repeat (gap) begin
				drive_cycle(1'b0, 1'b0, 1'($urandom), k == 14, at_cycle);
			end
			drive_cycle(k == 14, 1'b1, word[k], k == 14, at_cycle);
		end
		exp_cycle_q.push_back(at_cycle + 3);                // Two clocks after r0 is accepted
		sent++;
	endtask

	initial begin : compare_results
		logic [12:0] expected;
		int          waited;
		forever begin
			waited = 0;
			@(negedge clk);
			while (!syn_valid) begin
				waited++;
				if (waited > wait_limit) begin
					abort_run("timeout while waiting for syn_valid");
				end
				@(negedge clk);
			end
			if (exp_q.size() == 0 || exp_cycle_q.size() == 0) begin
				abort_run("syn_valid pulsed with no word outstanding");
			end
			expected = exp_q.pop_front();
			compare_value(32'(cycle), 32'(exp_cycle_q.pop_front()), "syn_valid cycle");
			compare_value(32'(syn1), 32'(expected[11:8]), "syn1");
			compare_value(32'(syn2), 32'(expected[7:4]), "syn2");
			compare_value(32'(syn3), 32'(expected[3:0]), "syn3");
			compare_value(32'(errors_present), 32'(expected[12]), "errors_present");
			checked++;
		end
	end

	initial begin : main_sequence
		int waited;
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		ce = 1'b0;
		data_in = 1'b0;
		cycle = 0;
		sent = 0;
		checked = 0;
		error_count = 0;
		void'($urandom(seed));
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		compare_value(32'(ready), 32'd1, "ready after reset");
		compare_value(32'(syn_valid), 32'd0, "syn_valid after reset");
		compare_value(32'({syn1, syn2, syn3}), 32'd0, "syndromes after reset");
		compare_value(32'(errors_present), 32'd0, "errors_present after reset");

		send_word(15'h0000, 1'b0, 1'b0);
		repeat (6) send_word(encode(7'($urandom)), 1'b0, 1'b0);
		for (int i = 0; i < 15; i++) begin
			send_word(encode(7'($urandom)) ^ (15'd1 << i), 1'b0, 1'b0); // S1 is alpha^i
		end
		repeat (10) send_word(add_errors(encode(7'($urandom)), 2), 1'b0, 1'b0);
		repeat (10) send_word(add_errors(encode(7'($urandom)), $urandom_range(0, 2)), 1'b1, 1'b0);
		send_word(add_errors(encode(7'($urandom)), 1), 1'b1, 1'b0);
		repeat (8) send_word(add_errors(encode(7'($urandom)), $urandom_range(0, 2)), 1'b1, 1'b1);

		@(posedge clk);
		start <= 1'b0;
		ce    <= 1'b0;
		waited = 0;
		while (checked < sent) begin
			waited++;
			if (waited > wait_limit) begin
				abort_run("timeout while waiting for the last results");
			end
			@(negedge clk);
		end
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
